// File: Makefile
# Verilator build and run of the integer execute subsystem testbench.

TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_int_exec_core
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
rtl/rv_exec_pkg.sv
rtl/register_file.sv
rtl/pipe_stage_reg.sv
rtl/instr_decoder.sv
rtl/operand_fetch.sv
rtl/int_alu.sv
rtl/execute_stage.sv
rtl/int_exec_core.sv
verification/tb_int_exec_core.sv

// File: rtl/execute_stage.sv
// Execute stage.
// Runs the ALU on the held issue packet, forms the result record,
// drives the register file write and the bypass path.

`timescale 1ns/1ps

module execute_stage (
    input  logic                    i_valid,
    input  rv_exec_pkg::issue_pkt_t i_pkt,
    output logic                    o_ready,
    output logic                    o_valid,
    output rv_exec_pkg::result_t    o_result,
    input  logic                    i_ready,
    output rv_exec_pkg::rf_write_t  o_write,
    output rv_exec_pkg::bypass_t    o_bypass
);

    logic [rv_exec_pkg::XLEN-1:0] alu_y;
    logic                         has_dest;
    logic                         do_write;

    int_alu u_alu (
        .i_op (i_pkt.alu_op),
        .i_a  (i_pkt.operand_a),
        .i_b  (i_pkt.operand_b),
        .o_y  (alu_y)
    );

    // x0 writes are dropped.
    assign has_dest = i_pkt.writes_rd && (i_pkt.rd != '0);
    assign do_write = i_valid && i_ready && has_dest;

    // ------------------------------------------------------------
    // Result record and write port.
    // ------------------------------------------------------------
    assign o_result.rd      = i_pkt.rd;
    assign o_result.value   = i_pkt.illegal ? '0 : alu_y;
    assign o_result.wrote   = do_write;
    assign o_result.illegal = i_pkt.illegal;

    assign o_write.en   = do_write;
    assign o_write.addr = i_pkt.rd;
    assign o_write.data = alu_y;

    // Forward whatever is held, stalled or not.
    assign o_bypass.valid = i_valid && has_dest;
    assign o_bypass.rd    = i_pkt.rd;
    assign o_bypass.value = alu_y;

    assign o_valid = i_valid;
    assign o_ready = i_ready;

endmodule

// File: rtl/instr_decoder.sv
// Instruction decoder for the RV64I integer subset.
// Register-register ops, register-immediate ops and LUI.
// Anything else, or a register index past NUM_REGS, is illegal.

`timescale 1ns/1ps

module instr_decoder #(
    parameter int NUM_REGS = 32
) (
    input  logic [31:0]           i_instr,
    output rv_exec_pkg::decoded_t o_dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad_index;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    always_comb begin
        o_dec           = '0;
        o_dec.rd        = i_instr[11:7];
        o_dec.alu_op    = rv_exec_pkg::ADD;
        o_dec.illegal   = 1'b1;
        o_dec.writes_rd = 1'b0;

        case (opcode)
            rv_exec_pkg::OP_REG: begin
                o_dec.rs1 = i_instr[19:15];
                o_dec.rs2 = i_instr[24:20];
                if (funct7 == 7'b0000000) begin
                    o_dec.illegal = 1'b0;
                    case (funct3)
                        3'b000:  o_dec.alu_op = rv_exec_pkg::ADD;
                        3'b001:  o_dec.alu_op = rv_exec_pkg::SLL;
                        3'b010:  o_dec.alu_op = rv_exec_pkg::SLT;
                        3'b011:  o_dec.alu_op = rv_exec_pkg::SLTU;
                        3'b100:  o_dec.alu_op = rv_exec_pkg::XOR;
                        3'b101:  o_dec.alu_op = rv_exec_pkg::SRL;
                        3'b110:  o_dec.alu_op = rv_exec_pkg::OR;
                        default: o_dec.alu_op = rv_exec_pkg::AND;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    // Only SUB and SRA use the alternate funct7.
                    if (funct3 == 3'b000) begin
                        o_dec.alu_op  = rv_exec_pkg::SUB;
                        o_dec.illegal = 1'b0;
                    end else if (funct3 == 3'b101) begin
                        o_dec.alu_op  = rv_exec_pkg::SRA;
                        o_dec.illegal = 1'b0;
                    end
                end
            end
            rv_exec_pkg::OP_IMM: begin
                o_dec.rs1     = i_instr[19:15];
                o_dec.use_imm = 1'b1;
                o_dec.imm     = {{(rv_exec_pkg::XLEN-12){i_instr[31]}}, i_instr[31:20]};
                o_dec.illegal = 1'b0;
                case (funct3)
                    3'b000: o_dec.alu_op = rv_exec_pkg::ADD;
                    3'b010: o_dec.alu_op = rv_exec_pkg::SLT;
                    3'b011: o_dec.alu_op = rv_exec_pkg::SLTU;
                    3'b100: o_dec.alu_op = rv_exec_pkg::XOR;
                    3'b110: o_dec.alu_op = rv_exec_pkg::OR;
                    3'b111: o_dec.alu_op = rv_exec_pkg::AND;
                    default: begin
                        // Shifts take a 6-bit shamt for RV64.
                        o_dec.imm = {{(rv_exec_pkg::XLEN-6){1'b0}}, i_instr[25:20]};
                        if (funct3 == 3'b001 && i_instr[31:26] == 6'b000000) begin
                            o_dec.alu_op = rv_exec_pkg::SLL;
                        end else if (funct3 == 3'b101 && i_instr[31:26] == 6'b000000) begin
                            o_dec.alu_op = rv_exec_pkg::SRL;
                        end else if (funct3 == 3'b101 && i_instr[31:26] == 6'b010000) begin
                            o_dec.alu_op = rv_exec_pkg::SRA;
                        end else begin
                            o_dec.illegal = 1'b1;
                        end
                    end
                endcase
            end
            rv_exec_pkg::OP_LUI: begin
                o_dec.use_imm = 1'b1;
                o_dec.imm     = {{(rv_exec_pkg::XLEN-32){i_instr[31]}}, i_instr[31:12], 12'b0};
                o_dec.alu_op  = rv_exec_pkg::PASS_B;
                o_dec.illegal = 1'b0;
            end
            default: ;
        endcase

        if (bad_index) begin
            o_dec.illegal = 1'b1;
        end
        o_dec.writes_rd = !o_dec.illegal;
    end

    // Reduced register files reject the upper indices.
    assign bad_index = (int'(i_instr[11:7]) >= NUM_REGS)
                       || (int'(o_dec.rs1) >= NUM_REGS)
                       || (int'(o_dec.rs2) >= NUM_REGS);

endmodule

// File: rtl/int_alu.sv
// 64-bit integer ALU.
// Add, subtract, logic, shifts, set-less-than and operand B pass.

`timescale 1ns/1ps

module int_alu (
    input  rv_exec_pkg::alu_op_e          i_op,
    input  logic [rv_exec_pkg::XLEN-1:0]  i_a,
    input  logic [rv_exec_pkg::XLEN-1:0]  i_b,
    output logic [rv_exec_pkg::XLEN-1:0]  o_y
);

    logic [5:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // RV64 shifts use the low 6 bits.
    assign shamt = i_b[5:0];

    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        case (i_op)
            rv_exec_pkg::ADD:    o_y = i_a + i_b;
            rv_exec_pkg::SUB:    o_y = i_a - i_b;
            rv_exec_pkg::SLL:    o_y = i_a << shamt;
            rv_exec_pkg::SLT: begin
                o_y = {{(rv_exec_pkg::XLEN-1){1'b0}}, lt_signed};
            end
            rv_exec_pkg::SLTU: begin
                o_y = {{(rv_exec_pkg::XLEN-1){1'b0}}, lt_unsigned};
            end
            rv_exec_pkg::XOR:    o_y = i_a ^ i_b;
            rv_exec_pkg::SRL:    o_y = i_a >> shamt;
            // Arithmetic shift keeps the sign.
            rv_exec_pkg::SRA:    o_y = $unsigned($signed(i_a) >>> shamt);
            rv_exec_pkg::OR:     o_y = i_a | i_b;
            rv_exec_pkg::AND:    o_y = i_a & i_b;
            rv_exec_pkg::PASS_B: o_y = i_b;
            default:             o_y = '0;
        endcase
    end

endmodule

// File: rtl/int_exec_core.sv
// Integer execute subsystem top level.
// Operand fetch, issue register, execute stage, result register
// and the register file, connected by valid/ready handshakes.

`timescale 1ns/1ps

module int_exec_core #(
    parameter int NUM_REGS = 32
) (
    input  logic                 clk,
    input  logic                 arstn,
    input  logic                 i_instr_valid,
    input  logic [31:0]          i_instr,
    output logic                 o_instr_ready,
    output logic                 o_result_valid,
    output rv_exec_pkg::result_t o_result,
    input  logic                 i_result_ready
);

    logic [rv_exec_pkg::REG_IDX_W-1:0] rd_addr_a;
    logic [rv_exec_pkg::REG_IDX_W-1:0] rd_addr_b;
    logic [rv_exec_pkg::XLEN-1:0]      rd_data_a;
    logic [rv_exec_pkg::XLEN-1:0]      rd_data_b;
    rv_exec_pkg::rf_write_t            rf_write;
    rv_exec_pkg::bypass_t              bypass;

    // Fetch to issue register.
    logic                              fetch_valid;
    logic                              fetch_ready;
    rv_exec_pkg::issue_pkt_t           fetch_pkt;

    // Issue register to execute.
    logic                              issue_valid;
    logic                              issue_ready;
    rv_exec_pkg::issue_pkt_t           issue_pkt;

    // Execute to result register.
    logic                              exec_valid;
    logic                              exec_ready;
    rv_exec_pkg::result_t              exec_result;

    operand_fetch #(
        .NUM_REGS (NUM_REGS)
    ) u_operand_fetch (
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_instr_ready (o_instr_ready),
        .o_rd_addr_a   (rd_addr_a),
        .o_rd_addr_b   (rd_addr_b),
        .i_rd_data_a   (rd_data_a),
        .i_rd_data_b   (rd_data_b),
        .i_bypass      (bypass),
        .o_issue_valid (fetch_valid),
        .o_issue       (fetch_pkt),
        .i_issue_ready (fetch_ready)
    );

    register_file #(
        .NUM_REGS (NUM_REGS)
    ) u_register_file (
        .clk         (clk),
        .arstn       (arstn),
        .i_rd_addr_a (rd_addr_a),
        .i_rd_addr_b (rd_addr_b),
        .i_write     (rf_write),
        .o_rd_data_a (rd_data_a),
        .o_rd_data_b (rd_data_b)
    );

    pipe_stage_reg #(
        .T (rv_exec_pkg::issue_pkt_t)
    ) u_issue_reg (
        .clk     (clk),
        .arstn   (arstn),
        .i_valid (fetch_valid),
        .o_ready (fetch_ready),
        .i_data  (fetch_pkt),
        .o_valid (issue_valid),
        .i_ready (issue_ready),
        .o_data  (issue_pkt)
    );

    execute_stage u_execute_stage (
        .i_valid  (issue_valid),
        .i_pkt    (issue_pkt),
        .o_ready  (issue_ready),
        .o_valid  (exec_valid),
        .o_result (exec_result),
        .i_ready  (exec_ready),
        .o_write  (rf_write),
        .o_bypass (bypass)
    );

    pipe_stage_reg #(
        .T (rv_exec_pkg::result_t)
    ) u_result_reg (
        .clk     (clk),
        .arstn   (arstn),
        .i_valid (exec_valid),
        .o_ready (exec_ready),
        .i_data  (exec_result),
        .o_valid (o_result_valid),
        .i_ready (i_result_ready),
        .o_data  (o_result)
    );

endmodule

// File: rtl/operand_fetch.sv
// Operand fetch stage.
// Decodes the incoming word, reads both sources from the register file,
// forwards from the issue register and builds the issue packet.

`timescale 1ns/1ps

module operand_fetch #(
    parameter int NUM_REGS = 32
) (
    input  logic                                i_instr_valid,
    input  logic [31:0]                         i_instr,
    output logic                                o_instr_ready,
    // Register file read side.
    output logic [rv_exec_pkg::REG_IDX_W-1:0]   o_rd_addr_a,
    output logic [rv_exec_pkg::REG_IDX_W-1:0]   o_rd_addr_b,
    input  logic [rv_exec_pkg::XLEN-1:0]        i_rd_data_a,
    input  logic [rv_exec_pkg::XLEN-1:0]        i_rd_data_b,
    // Forwarding from execute.
    input  rv_exec_pkg::bypass_t                i_bypass,
    // Issue side.
    output logic                                o_issue_valid,
    output rv_exec_pkg::issue_pkt_t             o_issue,
    input  logic                                i_issue_ready
);

    rv_exec_pkg::decoded_t        dec;
    logic [rv_exec_pkg::XLEN-1:0] src_a;
    logic [rv_exec_pkg::XLEN-1:0] src_b;

    instr_decoder #(
        .NUM_REGS (NUM_REGS)
    ) u_decoder (
        .i_instr (i_instr),
        .o_dec   (dec)
    );

    assign o_rd_addr_a = dec.rs1;
    assign o_rd_addr_b = dec.rs2;

    // Bypass valid already excludes x0.
    assign src_a = (i_bypass.valid && i_bypass.rd == dec.rs1) ? i_bypass.value : i_rd_data_a;
    assign src_b = (i_bypass.valid && i_bypass.rd == dec.rs2) ? i_bypass.value : i_rd_data_b;

    // ------------------------------------------------------------
    // Issue packet.
    // ------------------------------------------------------------
    assign o_issue.operand_a = src_a;
    assign o_issue.operand_b = dec.use_imm ? dec.imm : src_b;
    assign o_issue.alu_op    = dec.alu_op;
    assign o_issue.rd        = dec.rd;
    assign o_issue.writes_rd = dec.writes_rd;
    assign o_issue.illegal   = dec.illegal;

    // No storage here, handshake passes straight through.
    assign o_issue_valid = i_instr_valid;
    assign o_instr_ready = i_issue_ready;

endmodule

// File: rtl/pipe_stage_reg.sv
// One-entry valid/ready pipeline register.
// Payload type is a parameter; accepts a new word every cycle
// as long as the consumer keeps up.

`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arstn,
    // Upstream side.
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,
    // Downstream side.
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);

    logic valid_q;
    T     data_q;

    // Free when empty or draining this cycle.
    assign o_ready = !valid_q || i_ready;

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            valid_q <= 1'b0;
        end else if (i_valid && o_ready) begin
            valid_q <= 1'b1;
        end else if (i_ready) begin
            valid_q <= 1'b0;
        end
    end

    // Payload only.
    always_ff @(posedge clk) begin
        if (i_valid && o_ready) begin
            data_q <= i_data;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

endmodule

// File: rtl/register_file.sv
// Integer register file.
// Two combinational read ports and one synchronous write port,
// all entries cleared by reset, entry zero fixed at zero.

`timescale 1ns/1ps

module register_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                                       clk,
    input  logic                                       arstn,
    input  logic [rv_exec_pkg::REG_IDX_W-1:0]          i_rd_addr_a,
    input  logic [rv_exec_pkg::REG_IDX_W-1:0]          i_rd_addr_b,
    input  rv_exec_pkg::rf_write_t                     i_write,
    output logic [rv_exec_pkg::XLEN-1:0]               o_rd_data_a,
    output logic [rv_exec_pkg::XLEN-1:0]               o_rd_data_b
);

    logic [rv_exec_pkg::XLEN-1:0] regs [NUM_REGS];
    logic                         wr_hit;

    // Zero and out-of-range indices are never written.
    assign wr_hit = i_write.en && (i_write.addr != '0)
                    && (int'(i_write.addr) < NUM_REGS);

    // ------------------------------------------------------------
    // Write port.
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[i_write.addr] <= i_write.data;
        end
    end

    // ------------------------------------------------------------
    // Read ports.
    // ------------------------------------------------------------
    // x0 reads zero, as does any index past the array.
    assign o_rd_data_a = ((i_rd_addr_a == '0) || (int'(i_rd_addr_a) >= NUM_REGS))
                         ? '0 : regs[i_rd_addr_a];
    assign o_rd_data_b = ((i_rd_addr_b == '0) || (int'(i_rd_addr_b) >= NUM_REGS))
                         ? '0 : regs[i_rd_addr_b];

endmodule

// File: rtl/rv_exec_pkg.sv
// Shared definitions for the RV64I integer execute subsystem.
// Data and register index widths, major opcodes,
// the ALU operation enum and the packed records passed between stages.

package rv_exec_pkg;

    // ------------------------------------------------------------
    // Widths.
    // ------------------------------------------------------------
    localparam int XLEN      = 64;
    localparam int REG_IDX_W = 5;

    // ------------------------------------------------------------
    // Major opcodes.
    // ------------------------------------------------------------
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;

    // ALU operations. PASS_B forwards operand B for LUI.
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_e;

    // Decoder output.
    typedef struct packed {
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      imm;
        alu_op_e              alu_op;
        logic                 use_imm;
        logic                 writes_rd;
        logic                 illegal;
    } decoded_t;

    // Packet held in the issue register.
    typedef struct packed {
        logic [XLEN-1:0]      operand_a;
        logic [XLEN-1:0]      operand_b;
        alu_op_e              alu_op;
        logic [REG_IDX_W-1:0] rd;
        logic                 writes_rd;
        logic                 illegal;
    } issue_pkt_t;

    // Completed instruction record.
    typedef struct packed {
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      value;
        logic                 wrote;
        logic                 illegal;
    } result_t;

    // Register file write port.
    typedef struct packed {
        logic                 en;
        logic [REG_IDX_W-1:0] addr;
        logic [XLEN-1:0]      data;
    } rf_write_t;

    // Forwarding path from the issue register.
    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      value;
    } bypass_t;

endpackage

// File: verification/tb_int_exec_core.sv
// Testbench for the integer execute subsystem.
// Random instruction stream with frequent register dependencies,
// random input and output stalls, a reference model with an expected
// result queue, compare tasks and a cycle timeout.

`timescale 1ns/1ps

module tb_int_exec_core;

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 8;

    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;

    logic                 clk;
    logic                 arstn;
    logic                 i_instr_valid;
    logic [31:0]          i_instr;
    logic                 o_instr_ready;
    logic                 o_result_valid;
    rv_exec_pkg::result_t o_result;
    logic                 i_result_ready;

    integer               seed;
    int                   errors;
    int                   sent;
    int                   received;
    logic                 pending;
    logic [31:0]          rnd;
    rv_exec_pkg::result_t expected;
    rv_exec_pkg::result_t exp_q [$];
    logic [63:0]          model_regs [32];

    // Fields of the instruction currently offered.
    logic [31:0]          cur_word;
    int                   cur_op;
    logic [4:0]           cur_rd;
    logic [4:0]           cur_rs1;
    logic [4:0]           cur_rs2;
    logic [63:0]          cur_imm;
    logic                 cur_use_imm;
    logic                 cur_illegal;

    int_exec_core #(
        .NUM_REGS (32)
    ) uut (
        .clk            (clk),
        .arstn          (arstn),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_instr_ready  (o_instr_ready),
        .o_result_valid (o_result_valid),
        .o_result       (o_result),
        .i_result_ready (i_result_ready)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // Reference model.
    // ------------------------------------------------------------
    // Op codes: 0 add, 1 sub, 2 sll, 3 slt, 4 sltu, 5 xor,
    // 6 srl, 7 sra, 8 or, 9 and, 10 pass b.
    function automatic logic [63:0] alu_model(input int op, input logic [63:0] a,
                                              input logic [63:0] b);
        logic [5:0] sh;
        sh = b[5:0];
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a << sh;
            // Signed order differs from unsigned only when the signs differ.
            3:       return (a[63] != b[63]) ? {63'd0, a[63]} : {63'd0, (a < b)};
            4:       return (a < b) ? 64'd1 : 64'd0;
            5:       return a ^ b;
            6:       return a >> sh;
            // Logical shift with the vacated top bits filled by the sign.
            7:       return (a >> sh) | ({64{a[63]}} & ~(64'hffff_ffff_ffff_ffff >> sh));
            8:       return a | b;
            9:       return a & b;
            10:      return b;
            default: return 64'd0;
        endcase
    endfunction

    task automatic make_instr();
        logic [31:0] r_sel;
        logic [31:0] r_fld;
        logic [31:0] r_imm;
        int          kind;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r_sel = $random(seed);
        r_fld = $random(seed);
        r_imm = $random(seed);
        cur_rd      = {2'b00, r_fld[2:0]};
        cur_rs1     = {2'b00, r_fld[5:3]};
        cur_rs2     = {2'b00, r_fld[8:6]};
        cur_imm     = {{52{r_imm[11]}}, r_imm[11:0]};
        cur_use_imm = 1'b0;
        cur_illegal = 1'b0;
        kind        = (r_sel >> 8) % 20;
        f7          = 7'b0000000;
        if ((r_sel % 20) == 0) begin
            // Loads and OP-32 by opcode, the multiply group and a bad shift encoding.
            case (r_fld[10:9])
                2'd0:    cur_word = {r_imm[24:0], 7'b0000011};
                2'd1:    cur_word = {r_imm[24:0], 7'b0111011};
                2'd2: begin
                    cur_word = {7'b0000001, cur_rs2, cur_rs1, r_imm[14:12],
                                cur_rd, OPC_REG};
                end
                default: begin
                    cur_word = {6'b010000, r_imm[5:0], cur_rs1, 3'b001,
                                cur_rd, OPC_IMM};
                end
            endcase
            cur_rd      = cur_word[11:7];
            cur_illegal = 1'b1;
            cur_op      = 0;
        end else if (kind < 10) begin
            cur_op = kind;
            case (kind)
                0:       f3 = 3'b000;
                1:       f3 = 3'b000;
                2:       f3 = 3'b001;
                3:       f3 = 3'b010;
                4:       f3 = 3'b011;
                5:       f3 = 3'b100;
                6:       f3 = 3'b101;
                7:       f3 = 3'b101;
                8:       f3 = 3'b110;
                default: f3 = 3'b111;
            endcase
            if (kind == 1 || kind == 7) begin
                f7 = 7'b0100000;
            end
            cur_word = {f7, cur_rs2, cur_rs1, f3, cur_rd, OPC_REG};
        end else if (kind < 16) begin
            case (kind)
                10:      f3 = 3'b000;
                11:      f3 = 3'b010;
                12:      f3 = 3'b011;
                13:      f3 = 3'b100;
                14:      f3 = 3'b110;
                default: f3 = 3'b111;
            endcase
            case (f3)
                3'b000:  cur_op = 0;
                3'b010:  cur_op = 3;
                3'b011:  cur_op = 4;
                3'b100:  cur_op = 5;
                3'b110:  cur_op = 8;
                default: cur_op = 9;
            endcase
            cur_use_imm = 1'b1;
            cur_word    = {r_imm[11:0], cur_rs1, f3, cur_rd, OPC_IMM};
        end else if (kind < 19) begin
            // Shift immediates, 6-bit shamt.
            cur_use_imm = 1'b1;
            cur_imm     = {58'd0, r_imm[5:0]};
            f7          = (kind == 18) ? 7'b0100000 : 7'b0000000;
            f3          = (kind == 16) ? 3'b001 : 3'b101;
            cur_op      = (kind == 16) ? 2 : ((kind == 17) ? 6 : 7);
            cur_word    = {f7[6:1], r_imm[5:0], cur_rs1, f3, cur_rd, OPC_IMM};
        end else begin
            cur_use_imm = 1'b1;
            cur_rs1     = 5'd0;
            cur_imm     = {{32{r_imm[31]}}, r_imm[31:12], 12'h000};
            cur_op      = 10;
            cur_word    = {r_imm[31:12], cur_rd, OPC_LUI};
        end
    endtask

    // Computed at acceptance, in program order.
    task automatic predict_result();
        logic [63:0]          a;
        logic [63:0]          b;
        rv_exec_pkg::result_t r;
        r    = '0;
        r.rd = cur_rd;
        if (cur_illegal) begin
            r.illegal = 1'b1;
        end else begin
            a       = model_regs[cur_rs1];
            b       = cur_use_imm ? cur_imm : model_regs[cur_rs2];
            r.value = alu_model(cur_op, a, b);
            if (cur_rd != 5'd0) begin
                r.wrote             = 1'b1;
                model_regs[cur_rd] = r.value;
            end
        end
        exp_q.push_back(r);
    endtask

    // ------------------------------------------------------------
    // Compare tasks.
    // ------------------------------------------------------------
    task automatic check_result(input rv_exec_pkg::result_t got,
                                input rv_exec_pkg::result_t exp_r);
        if (got.rd !== exp_r.rd) begin
            $display("Error: o_result.rd got 0x%0h expected 0x%0h", got.rd, exp_r.rd);
            errors++;
        end
        if (got.value !== exp_r.value) begin
            $display("Error: o_result.value got 0x%0h expected 0x%0h",
                     got.value, exp_r.value);
            errors++;
        end
        if (got.wrote !== exp_r.wrote) begin
            $display("Error: o_result.wrote got 0x%0h expected 0x%0h",
                     got.wrote, exp_r.wrote);
            errors++;
        end
        if (got.illegal !== exp_r.illegal) begin
            $display("Error: o_result.illegal got 0x%0h expected 0x%0h",
                     got.illegal, exp_r.illegal);
            errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp_bit);
        if (got !== exp_bit) begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp_bit);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus and checking.
    // ------------------------------------------------------------
    initial begin
        seed           = 32'h20ca;
        errors         = 0;
        sent           = 0;
        received       = 0;
        pending        = 1'b0;
        arstn          = 1'b0;
        i_instr_valid  = 1'b0;
        i_instr        = '0;
        i_result_ready = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 64'd0;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;
        #1;
        compare_flag("o_result_valid", o_result_valid, 1'b0);
        compare_flag("o_instr_ready", o_instr_ready, 1'b1);

        while (sent < NUM_INSTR || exp_q.size() > 0) begin
            @(negedge clk);
            rnd            = $random(seed);
            i_result_ready = (rnd[1:0] != 2'b00);
            // An offered word stays put until it is taken.
            if (!pending) begin
                if (sent < NUM_INSTR && rnd[3:2] != 2'b00) begin
                    make_instr();
                    i_instr       = cur_word;
                    i_instr_valid = 1'b1;
                    pending       = 1'b1;
                end else begin
                    i_instr_valid = 1'b0;
                end
            end
            #1;
            if (o_result_valid && i_result_ready) begin
                if (exp_q.size() == 0) begin
                    $display("A result came out with no instruction outstanding");
                    errors++;
                end else begin
                    expected = exp_q.pop_front();
                    check_result(o_result, expected);
                    received++;
                end
            end
            if (i_instr_valid && o_instr_ready) begin
                predict_result();
                sent++;
                pending = 1'b0;
            end
        end

        // Nothing more may come out once every result is in.
        @(negedge clk);
        i_instr_valid  = 1'b0;
        i_result_ready = 1'b1;
        repeat (4) begin
            #1;
            if (o_result_valid) begin
                $display("An extra result came out after all instructions completed");
                errors++;
            end
            @(negedge clk);
        end

        $display("Checked %0d results, %0d errors", received, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Cycle limit.
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
